// File: hdl/secded_pkg.sv
package secded_pkg;

    localparam int DATA_W      = 95;
    localparam int CHECK_W     = 8;
    localparam int POS_W       = 7;
    localparam int IN_DEPTH    = 4;  // also the upstream's initial credits.
    localparam int OUT_CREDITS = 2;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [CHECK_W-1:0] check_t;

    typedef logic [$clog2(IN_DEPTH)-1:0]      fifo_ptr_t;
    typedef logic [$clog2(IN_DEPTH+1)-1:0]    fifo_cnt_t;
    typedef logic [$clog2(OUT_CREDITS+1)-1:0] credit_t;

    typedef struct packed {
        data_t  data;
        check_t check;   // stored check bits.
        logic   bypass;
    } ecc_req_t;

    typedef struct packed {
        data_t  data;
        check_t check_gen;  // regenerated from received data.
        logic   sbit_err;
        logic   dbit_err;
    } ecc_res_t;

    typedef struct packed {
        logic             odd;  // parity extension bit.
        logic [POS_W-1:0] pos;
    } syn_fields_t;

    typedef union packed {
        check_t      raw;
        syn_fields_t fld;
    } syndrome_u;

    // Column of data bit idx: the idx-th integer from 3 up that is not a
    // power of two, extended by bit 7 to odd weight.
    function automatic check_t check_column(input int unsigned idx);
        logic [POS_W-1:0] pos;
        int unsigned      n;
        check_t           col;
        pos = '0;
        n   = 0;
        for (int unsigned p = 3; p < (1 << POS_W); p++) begin
            if ((p & (p - 1)) != 0) begin  // skip powers of two.
                if (n == idx) begin
                    pos = p[POS_W-1:0];
                end
                n++;
            end
        end
        col = {~^pos, pos};
        return col;
    endfunction

endpackage

// File: hdl/ecc_ingress_fifo.sv
`timescale 1ns/1ns

module ecc_ingress_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  secded_pkg::ecc_req_t in_req,
    input  logic                 advance,
    output logic                 head_valid,
    output secded_pkg::ecc_req_t head,
    output logic                 in_credit
);

    import secded_pkg::*;

    ecc_req_t  mem [IN_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      pop;

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];
    assign pop        = advance && head_valid;  // head taken by the syndrome stage.

    // writes stay within the credits granted upstream.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= pop;  // one credit back per freed slot.
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/ecc_syndrome_stage.sv
`timescale 1ns/1ns

module ecc_syndrome_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  logic                  head_valid,
    input  secded_pkg::ecc_req_t  head,
    output logic                  s1_valid,
    output secded_pkg::ecc_req_t  s1_req,
    output secded_pkg::check_t    s1_check_gen,
    output secded_pkg::syndrome_u s1_syn
);

    import secded_pkg::*;

    check_t    check_gen;
    syndrome_u syn;

    // each set data bit contributes its column.
    always_comb begin
        check_gen = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (head.data[i]) begin
                check_gen = check_gen ^ check_column(i);
            end
        end
    end

    always_comb begin
        syn.raw = head.check ^ check_gen;  // zero when stored bits agree.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= head_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_req       <= head;
            s1_check_gen <= check_gen;
            s1_syn       <= syn;
        end
    end

endmodule

// File: hdl/ecc_correct_stage.sv
`timescale 1ns/1ns

module ecc_correct_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  logic                  s1_valid,
    input  secded_pkg::ecc_req_t  s1_req,
    input  secded_pkg::check_t    s1_check_gen,
    input  secded_pkg::syndrome_u s1_syn,
    output logic                  s2_valid,
    output secded_pkg::ecc_res_t  s2_res
);

    import secded_pkg::*;

    data_t    flip_mask;
    logic     syn_zero;
    logic     chk_err;
    logic     data_err;
    logic     sbit;
    logic     dbit;
    check_t   col;
    ecc_res_t res;

    // a data error needs both the parity bit and the position to agree.
    always_comb begin
        col = '0;
        for (int i = 0; i < DATA_W; i++) begin
            col          = check_column(i);
            flip_mask[i] = (s1_syn.fld.odd == col[CHECK_W-1]) &&
                           (s1_syn.fld.pos == col[POS_W-1:0]);
        end
    end

    assign syn_zero = (s1_syn.raw == '0);
    assign chk_err  = !syn_zero && ((s1_syn.raw & (s1_syn.raw - 1'b1)) == '0);  // one hot.
    assign data_err = |flip_mask;
    assign sbit     = data_err || chk_err;
    assign dbit     = !syn_zero && !sbit;  // includes uncorrectable odd weights.

    always_comb begin
        res.check_gen = s1_check_gen;
        if (s1_req.bypass) begin
            res.data     = s1_req.data;
            res.sbit_err = 1'b0;
            res.dbit_err = 1'b0;
        end else begin
            res.data     = s1_req.data ^ flip_mask;
            res.sbit_err = sbit;
            res.dbit_err = dbit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (advance) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s2_res <= res;
        end
    end

endmodule

// File: hdl/ecc_egress.sv
`timescale 1ns/1ns

module ecc_egress (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 s2_valid,
    input  secded_pkg::ecc_res_t s2_res,
    input  logic                 out_credit,
    output logic                 advance,
    output logic                 out_valid,
    output secded_pkg::ecc_res_t out_res
);

    import secded_pkg::*;

    logic     pend;
    ecc_res_t pend_res;
    credit_t  credit_cnt;
    logic     has_credit;

    assign has_credit = (credit_cnt != '0);
    assign out_valid  = pend && has_credit;
    assign out_res    = pend_res;
    assign advance    = !pend || has_credit;  // slot frees as the result leaves.

    always_ff @(posedge clk) begin
        if (rst) begin
            pend       <= 1'b0;
            credit_cnt <= credit_t'(OUT_CREDITS);
        end else begin
            if (advance) begin
                pend <= s2_valid;
            end
            case ({out_credit, out_valid})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;  // returned and spent together.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pend_res <= s2_res;
        end
    end

endmodule

// File: hdl/ecc_95_top.sv
`timescale 1ns/1ns

module ecc_95_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  secded_pkg::ecc_req_t in_req,
    input  logic                 out_credit,
    output logic                 in_credit,
    output logic                 out_valid,
    output secded_pkg::ecc_res_t out_res
);

    import secded_pkg::*;

    logic      advance;  // common stall for the whole pipe.
    logic      head_valid;
    ecc_req_t  head;
    logic      s1_valid;
    ecc_req_t  s1_req;
    check_t    s1_check_gen;
    syndrome_u s1_syn;
    logic      s2_valid;
    ecc_res_t  s2_res;

    ecc_ingress_fifo i_ingress (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .advance    (advance),
        .head_valid (head_valid),
        .head       (head),
        .in_credit  (in_credit)
    );

    ecc_syndrome_stage i_syndrome (
        .clk          (clk),
        .rst          (rst),
        .advance      (advance),
        .head_valid   (head_valid),
        .head         (head),
        .s1_valid     (s1_valid),
        .s1_req       (s1_req),
        .s1_check_gen (s1_check_gen),
        .s1_syn       (s1_syn)
    );

    ecc_correct_stage i_correct (
        .clk          (clk),
        .rst          (rst),
        .advance      (advance),
        .s1_valid     (s1_valid),
        .s1_req       (s1_req),
        .s1_check_gen (s1_check_gen),
        .s1_syn       (s1_syn),
        .s2_valid     (s2_valid),
        .s2_res       (s2_res)
    );

    ecc_egress i_egress (
        .clk        (clk),
        .rst        (rst),
        .s2_valid   (s2_valid),
        .s2_res     (s2_res),
        .out_credit (out_credit),
        .advance    (advance),
        .out_valid  (out_valid),
        .out_res    (out_res)
    );

endmodule

// File: verification/ecc_95_checker.sv
`timescale 1ns/1ns

module ecc_95_checker (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic out_valid,
    input logic out_credit,
    input logic in_credit
);

    import secded_pkg::*;

    int   mirror;     // downstream credits as the receiver sees them.
    int   in_flight;  // requests not yet answered by a credit.
    int   fails;      // failed assertions, read by the testbench.
    logic rst_seen;

    always_ff @(posedge clk) begin
        if (rst) begin
            rst_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mirror <= OUT_CREDITS;
        end else if (out_credit && !out_valid) begin
            mirror <= mirror + 1;
        end else if (out_valid && !out_credit) begin
            mirror <= mirror - 1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 0;
        end else if (in_valid && !in_credit) begin
            in_flight <= in_flight + 1;
        end else if (in_credit && !in_valid) begin
            in_flight <= in_flight - 1;
        end
    end

    credit_avail: assert property (@(posedge clk) disable iff (rst) out_valid |-> mirror > 0)
        else begin
            $error("out_valid raised with no downstream credit");
            fails++;
        end

    credit_bound: assert property (@(posedge clk) disable iff (rst) mirror <= OUT_CREDITS)
        else begin
            $error("more downstream credits returned than granted");
            fails++;
        end

    // each credit pulse frees one buffered request.
    credit_pulse: assert property (@(posedge clk) disable iff (rst) in_credit |-> in_flight > 0)
        else begin
            $error("in_credit returned with no request outstanding");
            fails++;
        end

    credit_room: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> in_flight < IN_DEPTH)
        else begin
            $error("request sent into a full ingress buffer");
            fails++;
        end

    reset_quiet: assert property (@(posedge clk) rst && rst_seen |-> !out_valid && !in_credit)
        else begin
            $error("out_valid or in_credit high during reset");
            fails++;
        end

endmodule

bind ecc_95_top ecc_95_checker i_checker (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .in_credit  (in_credit)
);

// File: verification/ecc_95_tb.sv
`timescale 1ns/1ns

module ecc_95_tb;

    import secded_pkg::*;

    localparam int SEED       = 51323;
    localparam int NUM_CLEAN  = 16;
    localparam int NUM_DOUBLE = 16;
    localparam int NUM_BYPASS = 8;
    localparam int NUM_BP     = 12;
    localparam int TOTAL_REQS = NUM_CLEAN + DATA_W + CHECK_W + NUM_DOUBLE + NUM_BYPASS + NUM_BP;

    logic     clk;
    logic     rst;
    logic     in_valid;
    ecc_req_t in_req;
    logic     out_credit;
    logic     in_credit;
    logic     out_valid;
    ecc_res_t out_res;

    check_t   col_tab [DATA_W];  // model columns.
    ecc_res_t exp_q [$];
    int       sent;
    int       returned;  // upstream credits given back by the DUT.
    int       received;
    int       owed;      // downstream credits not yet returned.
    int       errors;
    int       checks;
    logic     hold_credits;
    int       credit_gap;

    ecc_95_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_res    (out_res)
    );

    always #20 clk = ~clk;

    task automatic compare(input logic [127:0] got, input logic [127:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    // i-th non power of two from 3 up, then made odd weight by bit 7.
    task automatic build_columns();
        int p;
        p = 3;
        for (int i = 0; i < DATA_W; i++) begin
            while ($countones(p) == 1) begin
                p++;
            end
            col_tab[i] = {1'b0, p[6:0]};
            if ($countones(col_tab[i]) % 2 == 0) begin
                col_tab[i][7] = 1'b1;
            end
            p++;
        end
    endtask

    function automatic check_t encode(input data_t d);
        check_t c;
        for (int k = 0; k < CHECK_W; k++) begin
            c[k] = 1'b0;
            for (int i = 0; i < DATA_W; i++) begin
                if (col_tab[i][k]) begin
                    c[k] = c[k] ^ d[i];
                end
            end
        end
        return c;
    endfunction

    function automatic data_t random_data();
        logic [95:0] w;
        w = {$urandom, $urandom, $urandom};
        return w[DATA_W-1:0];
    endfunction

    function automatic ecc_req_t build_req(input data_t d, input check_t c, input logic byp);
        ecc_req_t r;
        r.data   = d;
        r.check  = c;
        r.bypass = byp;
        return r;
    endfunction

    function automatic ecc_res_t build_res(input data_t d, input check_t cg, input logic sbit,
                                           input logic dbit);
        ecc_res_t r;
        r.data      = d;
        r.check_gen = cg;
        r.sbit_err  = sbit;
        r.dbit_err  = dbit;
        return r;
    endfunction

    function automatic int credits_left();
        return IN_DEPTH + returned - sent;
    endfunction

    task automatic send(input ecc_req_t req, input ecc_res_t exp);
        @(posedge clk);
        while (credits_left() == 0) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
        in_valid <= 1'b1;
        in_req   <= req;
        sent++;
        exp_q.push_back(exp);
    endtask

    task automatic receive(input ecc_res_t res);
        if (exp_q.size() == 0) begin
            errors++;
            $display("error at %0t ns: result arrived with no request outstanding", $time);
        end else begin
            compare(128'(res), 128'(exp_q.pop_front()), $sformatf("result %0d", received));
        end
        received++;
        owed++;
    endtask

    // samples at the edge and gives downstream credits back every credit_gap cycles.
    task automatic watch_outputs();
        int gap_cnt;
        gap_cnt = 0;
        forever begin
            @(posedge clk);
            out_credit <= 1'b0;
            if (in_credit) begin
                returned <= returned + 1;
            end
            if (out_valid) begin
                receive(out_res);
            end
            gap_cnt++;
            if (owed > 0 && !hold_credits && gap_cnt >= credit_gap) begin
                out_credit <= 1'b1;
                owed--;
                gap_cnt = 0;
            end
        end
    endtask

    task automatic drain();
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic test_clean();
        data_t d;
        for (int n = 0; n < NUM_CLEAN; n++) begin
            d = random_data();
            send(build_req(d, encode(d), 1'b0), build_res(d, encode(d), 1'b0, 1'b0));
        end
        drain();
    endtask

    task automatic test_single_data();
        data_t d;
        data_t bad;
        for (int i = 0; i < DATA_W; i++) begin
            d      = random_data();
            bad    = d;
            bad[i] = ~bad[i];
            send(build_req(bad, encode(d), 1'b0), build_res(d, encode(bad), 1'b1, 1'b0));
        end
        drain();
    endtask

    task automatic test_single_check();
        data_t  d;
        check_t c;
        for (int k = 0; k < CHECK_W; k++) begin
            d    = random_data();
            c    = encode(d);
            c[k] = ~c[k];
            send(build_req(d, c, 1'b0), build_res(d, encode(d), 1'b1, 1'b0));
        end
        drain();
    endtask

    task automatic test_double_data();
        data_t d;
        data_t bad;
        int    i;
        int    j;
        for (int n = 0; n < NUM_DOUBLE; n++) begin
            d      = random_data();
            i      = $urandom % DATA_W;
            j      = (i + 1 + $urandom % (DATA_W - 1)) % DATA_W;  // never equal to i.
            bad    = d;
            bad[i] = ~bad[i];
            bad[j] = ~bad[j];
            send(build_req(bad, encode(d), 1'b0), build_res(bad, encode(bad), 1'b0, 1'b1));
        end
        drain();
    endtask

    task automatic test_bypass();
        data_t d;
        data_t bad;
        for (int n = 0; n < NUM_BYPASS; n++) begin
            d          = random_data();
            bad        = d;
            bad[n * 7] = ~bad[n * 7];
            if (n % 2 == 1) begin
                bad[n * 11 + 3] = ~bad[n * 11 + 3];  // second flip on odd rounds.
            end
            send(build_req(bad, encode(d), 1'b1), build_res(bad, encode(bad), 1'b0, 1'b0));
        end
        drain();
    endtask

    task automatic test_back_pressure();
        data_t d;
        @(posedge clk);
        hold_credits <= 1'b1;
        fork
            for (int n = 0; n < NUM_BP; n++) begin
                d = random_data();
                send(build_req(d, encode(d), 1'b0), build_res(d, encode(d), 1'b0, 1'b0));
            end
            begin
                repeat (40) @(posedge clk);
                compare(128'(credits_left()), 128'(0), "upstream credits with the pipe frozen");
                hold_credits <= 1'b0;
                credit_gap   <= 5;
            end
        join
        drain();
        credit_gap <= 1;
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_req       = '0;
        out_credit   = 1'b0;
        hold_credits = 1'b0;
        credit_gap   = 1;
        sent         = 0;
        returned     = 0;
        received     = 0;
        owed         = 0;
        errors       = 0;
        checks       = 0;
        void'($urandom(SEED));
        build_columns();
        compare(128'(col_tab[0]), 128'(8'h83), "column of data bit 0");
        compare(128'(col_tab[94]), 128'(8'he6), "column of data bit 94");
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        fork
            watch_outputs();
        join_none
        test_clean();
        test_single_data();
        test_single_check();
        test_double_data();
        test_bypass();
        test_back_pressure();
        compare(128'(received), 128'(sent), "results received against requests sent");
        compare(128'(i_dut.i_checker.fails), 128'(0), "assertions failed in the checker");
        $display("checks %0d, errors %0d, requests %0d", checks, errors, sent);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (TOTAL_REQS * 20 + 200) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", TOTAL_REQS * 20 + 200);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: sources.f
hdl/secded_pkg.sv
hdl/ecc_ingress_fifo.sv
hdl/ecc_syndrome_stage.sv
hdl/ecc_correct_stage.sv
hdl/ecc_egress.sv
hdl/ecc_95_top.sv
verification/ecc_95_checker.sv
verification/ecc_95_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the SECDED pipeline testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module ecc_95_tb -f sources.f -o sim_ecc_95

# the simulator status is not trusted alone; the pass line decides.
out=$(./obj_dir/sim_ecc_95 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Done: no errors'
